/* hw/mcpu_pkg.sv */
`default_nettype none

package mcpu_pkg;

  localparam int num_lanes = 4;   // Instructions per packet
  localparam int xlen      = 32;
  localparam int reg_num_w = 5;
  localparam int num_regs  = 2 ** reg_num_w;
  localparam int paddr_w   = 28;  // Packet address, one step per 128 bits
  localparam int packet_w  = num_lanes * xlen;
  localparam int imm_w     = 18;

  typedef enum logic [3:0] {
    op_nop  = 4'd0,
    op_movi = 4'd1,   // Load sign-extended immediate
    op_add  = 4'd2,
    op_sub  = 4'd3,
    op_and  = 4'd4,
    op_or   = 4'd5,
    op_xor  = 4'd6
  } opcode_e;

  // Immediate spans rt and imm_lo
  typedef struct packed {
    opcode_e     opcode;
    logic [4:0]  rd;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [12:0] imm_lo;
  } inst_t;

  typedef struct packed {
    logic [packet_w-1:0] packet;  // Lane 0 in the low word
    logic [paddr_w-1:0]  paddr;
  } fetch_pkt_t;

  typedef struct packed {
    logic                 we;
    opcode_e              opcode;
    logic [reg_num_w-1:0] rd;
    logic [xlen-1:0]      op_a;
    logic [xlen-1:0]      op_b;
  } dec_lane_t;

  typedef dec_lane_t [num_lanes-1:0] dec_bundle_t;

  typedef struct packed {
    logic                 we;
    logic [reg_num_w-1:0] rd;
    logic [xlen-1:0]      data;
  } res_lane_t;

  typedef res_lane_t [num_lanes-1:0] res_bundle_t;

endpackage

`default_nettype wire

/* hw/mcpu_wb_if.sv */
`timescale 1ns/100ps
`default_nettype none

// Retiring bundle, seen by regfile and scoreboard
interface mcpu_wb_if;
  import mcpu_pkg::*;

  logic        valid;   // High for one cycle per retired packet
  res_bundle_t bundle;

  modport source (
    output valid,
    output bundle
  );

  modport sink (
    input valid,
    input bundle
  );

endinterface

`default_nettype wire

/* hw/mcpu_pipe_reg.sv */
`timescale 1ns/100ps
`default_nettype none

module mcpu_pipe_reg #(
  parameter type payload_t = logic
) (
  input  logic     clkrst_core_clk,
  input  logic     reset,
  input  logic     in_valid,
  output logic     in_ready,
  input  payload_t in_data,
  output logic     out_valid,
  input  logic     out_ready,   // Downstream takes out_data this cycle
  output payload_t out_data
);

  // Empty or draining
  assign in_ready = ~out_valid | out_ready;

  always_ff @(posedge clkrst_core_clk) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else if (in_ready) begin
      out_valid <= in_valid;
    end
  end

  always_ff @(posedge clkrst_core_clk) begin
    if (in_ready) begin
      out_data <= in_data;
    end
  end

endmodule

`default_nettype wire

/* hw/mcpu_fetch.sv */
`timescale 1ns/100ps
`default_nettype none

module mcpu_fetch (
  input  logic                            clkrst_core_clk,
  input  logic                            reset,
  output logic                            f2ic_valid,
  output logic [mcpu_pkg::paddr_w-1:0]    f2ic_paddr,
  input  logic                            ic2f_ready,
  input  logic [mcpu_pkg::packet_w-1:0]   ic2f_packet,
  input  logic                            f2d_ready,
  output logic                            f2d_valid,
  output mcpu_pkg::fetch_pkt_t            f2d_data
);
  import mcpu_pkg::*;

  logic       buf_valid;   // Returned packet waiting for decode
  fetch_pkt_t buf_pkt;
  logic       transfer;

  // Request only while the buffer is free or about to drain
  assign f2ic_valid = ~buf_valid | f2d_ready;
  assign transfer   = f2ic_valid & ic2f_ready;

  always_ff @(posedge clkrst_core_clk) begin
    if (reset) begin
      buf_valid  <= 1'b0;
      f2ic_paddr <= '0;
    end else begin
      if (f2ic_valid) begin
        buf_valid <= transfer;
      end
      if (transfer) begin
        f2ic_paddr <= f2ic_paddr + 1'b1;   // Next sequential packet
      end
    end
  end

  always_ff @(posedge clkrst_core_clk) begin
    if (transfer) begin
      buf_pkt.packet <= ic2f_packet;
      buf_pkt.paddr  <= f2ic_paddr;
    end
  end

  assign f2d_valid = buf_valid;
  assign f2d_data  = buf_pkt;

endmodule

`default_nettype wire

/* hw/mcpu_decode.sv */
`timescale 1ns/100ps
`default_nettype none

module mcpu_decode (
  input  logic                                                     f2d_valid,
  input  mcpu_pkg::fetch_pkt_t                                     f2d_data,
  output logic [mcpu_pkg::num_lanes-1:0][mcpu_pkg::reg_num_w-1:0]  rs_num,
  output logic [mcpu_pkg::num_lanes-1:0][mcpu_pkg::reg_num_w-1:0]  rt_num,
  input  logic [mcpu_pkg::num_lanes-1:0][mcpu_pkg::xlen-1:0]       rs_data,
  input  logic [mcpu_pkg::num_lanes-1:0][mcpu_pkg::xlen-1:0]       rt_data,
  input  logic [mcpu_pkg::num_regs-1:0]                            pending,
  output logic                                                     d2x_valid,
  output mcpu_pkg::dec_bundle_t                                    d2x_data
);
  import mcpu_pkg::*;

  inst_t [num_lanes-1:0]          inst;
  logic  [num_lanes-1:0]          known_op;
  logic  [num_lanes-1:0]          reads_regs;   // Lane uses rs and rt
  logic  [num_lanes-1:0]          lane_stall;
  logic  [num_lanes-1:0][imm_w-1:0] imm;

  always_comb begin
    for (int l = 0; l < num_lanes; l++) begin
      inst[l] = inst_t'(f2d_data.packet[l*xlen +: xlen]);
      imm[l]  = {inst[l].rt, inst[l].imm_lo};

      unique case (inst[l].opcode)
        op_add, op_sub, op_and, op_or, op_xor: begin
          known_op[l]   = 1'b1;
          reads_regs[l] = 1'b1;
        end
        op_nop, op_movi: begin
          known_op[l]   = 1'b1;
          reads_regs[l] = 1'b0;
        end
        default: begin
          known_op[l]   = 1'b0;
          reads_regs[l] = 1'b0;
        end
      endcase

      rs_num[l] = inst[l].rs;
      rt_num[l] = inst[l].rt;

      // Wait until both sources are written back
      lane_stall[l] = reads_regs[l] & (pending[inst[l].rs] | pending[inst[l].rt]);

      d2x_data[l].opcode = inst[l].opcode;
      d2x_data[l].rd     = inst[l].rd;
      d2x_data[l].we     = known_op[l] && inst[l].opcode != op_nop && inst[l].rd != '0;
      d2x_data[l].op_a   = rs_data[l];
      if (inst[l].opcode == op_movi) begin
        d2x_data[l].op_b = {{(xlen-imm_w){imm[l][imm_w-1]}}, imm[l]};
      end else begin
        d2x_data[l].op_b = rt_data[l];
      end
    end
  end

  assign d2x_valid = f2d_valid & ~|lane_stall;

endmodule

`default_nettype wire

/* hw/mcpu_scoreboard.sv */
`timescale 1ns/100ps
`default_nettype none

module mcpu_scoreboard (
  input  logic                          clkrst_core_clk,
  input  logic                          reset,
  input  logic                          issue_valid,
  input  logic                          issue_ready,
  input  mcpu_pkg::dec_bundle_t         issue_data,
  mcpu_wb_if.sink                       wb,
  output logic [mcpu_pkg::num_regs-1:0] pending
);
  import mcpu_pkg::*;

  logic [num_regs-1:0] pending_next;

  always_comb begin
    pending_next = pending;
    if (wb.valid) begin
      for (int l = 0; l < num_lanes; l++) begin
        if (wb.bundle[l].we) begin
          pending_next[wb.bundle[l].rd] = 1'b0;
        end
      end
    end
    // A new write to the same rd keeps the bit set
    if (issue_valid && issue_ready) begin
      for (int l = 0; l < num_lanes; l++) begin
        if (issue_data[l].we) begin
          pending_next[issue_data[l].rd] = 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clkrst_core_clk) begin
    if (reset) begin
      pending <= '0;
    end else begin
      pending <= pending_next;
    end
  end

endmodule

`default_nettype wire

/* hw/mcpu_regfile.sv */
`timescale 1ns/100ps
`default_nettype none

module mcpu_regfile (
  input  logic                                                     clkrst_core_clk,
  input  logic                                                     reset,
  input  logic [mcpu_pkg::num_lanes-1:0][mcpu_pkg::reg_num_w-1:0]  rs_num,
  input  logic [mcpu_pkg::num_lanes-1:0][mcpu_pkg::reg_num_w-1:0]  rt_num,
  output logic [mcpu_pkg::num_lanes-1:0][mcpu_pkg::xlen-1:0]       rs_data,
  output logic [mcpu_pkg::num_lanes-1:0][mcpu_pkg::xlen-1:0]       rt_data,
  mcpu_wb_if.sink                                                  wb
);
  import mcpu_pkg::*;

  logic [xlen-1:0] regs [num_regs];

  always_ff @(posedge clkrst_core_clk) begin
    if (reset) begin
      for (int r = 0; r < num_regs; r++) begin
        regs[r] <= '0;
      end
    end else if (wb.valid) begin
      // Higher lane lands last on a shared rd
      for (int l = 0; l < num_lanes; l++) begin
        if (wb.bundle[l].we) begin
          regs[wb.bundle[l].rd] <= wb.bundle[l].data;
        end
      end
    end
  end

  // Eight combinational read ports
  always_comb begin
    for (int l = 0; l < num_lanes; l++) begin
      rs_data[l] = (rs_num[l] == '0) ? '0 : regs[rs_num[l]];
      rt_data[l] = (rt_num[l] == '0) ? '0 : regs[rt_num[l]];
    end
  end

endmodule

`default_nettype wire

/* hw/mcpu_execute.sv */
`timescale 1ns/100ps
`default_nettype none

module mcpu_execute (
  input  mcpu_pkg::dec_bundle_t x_data,
  output mcpu_pkg::res_bundle_t x_result
);
  import mcpu_pkg::*;

  always_comb begin
    for (int l = 0; l < num_lanes; l++) begin
      x_result[l].we = x_data[l].we;
      x_result[l].rd = x_data[l].rd;

      unique case (x_data[l].opcode)
        op_movi: x_result[l].data = x_data[l].op_b;   // Already sign-extended
        op_add:  x_result[l].data = x_data[l].op_a + x_data[l].op_b;
        op_sub:  x_result[l].data = x_data[l].op_a - x_data[l].op_b;
        op_and:  x_result[l].data = x_data[l].op_a & x_data[l].op_b;
        op_or:   x_result[l].data = x_data[l].op_a | x_data[l].op_b;
        op_xor:  x_result[l].data = x_data[l].op_a ^ x_data[l].op_b;
        default: x_result[l].data = '0;   // nop and invalid, we is low
      endcase
    end
  end

endmodule

`default_nettype wire

/* hw/mcpu_core.sv */
`timescale 1ns/100ps
`default_nettype none

module mcpu_core (
  input  logic                                              clkrst_core_clk,
  input  logic                                              reset,
  output logic                                              f2ic_valid,
  output logic [mcpu_pkg::paddr_w-1:0]                      f2ic_paddr,
  input  logic                                              ic2f_ready,
  input  logic [mcpu_pkg::packet_w-1:0]                     ic2f_packet,
  output logic                                              retire_valid,
  output logic [mcpu_pkg::num_lanes-1:0]                    retire_we,
  output logic [mcpu_pkg::num_lanes*mcpu_pkg::reg_num_w-1:0] retire_rd_num,
  output logic [mcpu_pkg::num_lanes*mcpu_pkg::xlen-1:0]     retire_rd_data
);
  import mcpu_pkg::*;

  // Fetch to decode
  logic        f_valid, f2d_in_ready, dcd_valid, f2d_out_ready;
  fetch_pkt_t  f_data, dcd_data;

  // Decode to execute
  logic        d_valid, d2x_in_ready, x_valid, x2wb_in_ready;
  dec_bundle_t d_data, x_data;
  res_bundle_t x_result;

  logic [num_lanes-1:0][reg_num_w-1:0] rs_num, rt_num;
  logic [num_lanes-1:0][xlen-1:0]      rs_data, rt_data;
  logic [num_regs-1:0]                 pending;

  mcpu_wb_if wb_if ();

  assign f2d_out_ready = d_valid & d2x_in_ready;   // Decode issues this cycle

  mcpu_fetch fetch_i (
    .clkrst_core_clk (clkrst_core_clk),
    .reset           (reset),
    .f2ic_valid      (f2ic_valid),
    .f2ic_paddr      (f2ic_paddr),
    .ic2f_ready      (ic2f_ready),
    .ic2f_packet     (ic2f_packet),
    .f2d_ready       (f2d_in_ready),
    .f2d_valid       (f_valid),
    .f2d_data        (f_data)
  );

  mcpu_pipe_reg #(.payload_t(fetch_pkt_t)) f2d_reg (
    .clkrst_core_clk (clkrst_core_clk),
    .reset           (reset),
    .in_valid        (f_valid),
    .in_ready        (f2d_in_ready),
    .in_data         (f_data),
    .out_valid       (dcd_valid),
    .out_ready       (f2d_out_ready),
    .out_data        (dcd_data)
  );

  mcpu_decode decode_i (
    .f2d_valid (dcd_valid),
    .f2d_data  (dcd_data),
    .rs_num    (rs_num),
    .rt_num    (rt_num),
    .rs_data   (rs_data),
    .rt_data   (rt_data),
    .pending   (pending),
    .d2x_valid (d_valid),
    .d2x_data  (d_data)
  );

  mcpu_scoreboard scoreboard_i (
    .clkrst_core_clk (clkrst_core_clk),
    .reset           (reset),
    .issue_valid     (d_valid),
    .issue_ready     (d2x_in_ready),
    .issue_data      (d_data),
    .wb              (wb_if.sink),
    .pending         (pending)
  );

  mcpu_regfile regfile_i (
    .clkrst_core_clk (clkrst_core_clk),
    .reset           (reset),
    .rs_num          (rs_num),
    .rt_num          (rt_num),
    .rs_data         (rs_data),
    .rt_data         (rt_data),
    .wb              (wb_if.sink)
  );

  mcpu_pipe_reg #(.payload_t(dec_bundle_t)) d2x_reg (
    .clkrst_core_clk (clkrst_core_clk),
    .reset           (reset),
    .in_valid        (d_valid),
    .in_ready        (d2x_in_ready),
    .in_data         (d_data),
    .out_valid       (x_valid),
    .out_ready       (x2wb_in_ready),   // Execute is single cycle
    .out_data        (x_data)
  );

  mcpu_execute execute_i (
    .x_data   (x_data),
    .x_result (x_result)
  );

  // Writeback never back-pressures
  mcpu_pipe_reg #(.payload_t(res_bundle_t)) x2wb_reg (
    .clkrst_core_clk (clkrst_core_clk),
    .reset           (reset),
    .in_valid        (x_valid),
    .in_ready        (x2wb_in_ready),
    .in_data         (x_result),
    .out_valid       (wb_if.valid),
    .out_ready       (1'b1),
    .out_data        (wb_if.bundle)
  );

  assign retire_valid = wb_if.valid;

  always_comb begin
    for (int l = 0; l < num_lanes; l++) begin
      retire_we[l] = wb_if.valid & wb_if.bundle[l].we;   // Payload is don't-care when idle
      retire_rd_num[l*reg_num_w +: reg_num_w] = wb_if.bundle[l].rd;
      retire_rd_data[l*xlen +: xlen]          = wb_if.bundle[l].data;
    end
  end

endmodule

`default_nettype wire

/* dv/mcpu_core_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module mcpu_core_tb;
  import mcpu_pkg::*;

  localparam int num_rows    = 9;
  localparam int retire_wait = 200;   // Cycles per wait for a retire

  logic                           clkrst_core_clk;
  logic                           reset;
  logic                           f2ic_valid;
  logic [paddr_w-1:0]             f2ic_paddr;
  logic                           ic2f_ready;
  logic [packet_w-1:0]            ic2f_packet;
  logic                           retire_valid;
  logic [num_lanes-1:0]           retire_we;
  logic [num_lanes*reg_num_w-1:0] retire_rd_num;
  logic [num_lanes*xlen-1:0]      retire_rd_data;

  // One row per packet with lane 0 in the low word
  logic [packet_w-1:0]            prog     [num_rows];
  logic [num_lanes-1:0]           exp_we   [num_rows];
  logic [num_lanes*reg_num_w-1:0] exp_rd   [num_rows];
  logic [num_lanes*xlen-1:0]      exp_data [num_rows];
  string                          row_name [num_rows];

  int errors;
  int tests_run;
  int tests_failed;

  mcpu_core mcpu_core_i (
    .clkrst_core_clk (clkrst_core_clk),
    .reset           (reset),
    .f2ic_valid      (f2ic_valid),
    .f2ic_paddr      (f2ic_paddr),
    .ic2f_ready      (ic2f_ready),
    .ic2f_packet     (ic2f_packet),
    .retire_valid    (retire_valid),
    .retire_we       (retire_we),
    .retire_rd_num   (retire_rd_num),
    .retire_rd_data  (retire_rd_data)
  );

  initial clkrst_core_clk = 1'b0;
  always #50 clkrst_core_clk = ~clkrst_core_clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] alu_inst(input logic [3:0] op, input int rd, rs, rt);
    return {op, 5'(rd), 5'(rs), 5'(rt), 13'd0};
  endfunction

  function automatic logic [31:0] movi_inst(input int rd, input logic [17:0] imm);
    return {4'd1, 5'(rd), 5'd0, imm};   // Immediate fills bits 17:0
  endfunction

  function automatic logic [packet_w-1:0] packet_at(input logic [paddr_w-1:0] paddr);
    if (paddr < num_rows) begin
      return prog[int'(paddr)];
    end
    return '0;   // Nop packets past the table
  endfunction

  task automatic add_row(input int r, input string name,
                         input logic [31:0] i0, i1, i2, i3,
                         input logic [3:0] we,
                         input int rd0, rd1, rd2, rd3,
                         input logic [31:0] d0, d1, d2, d3);
    row_name[r] = name;
    prog[r]     = {i3, i2, i1, i0};
    exp_we[r]   = we;
    exp_rd[r]   = {5'(rd3), 5'(rd2), 5'(rd1), 5'(rd0)};
    exp_data[r] = {d3, d2, d1, d0};
  endtask

  task automatic compare(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic report_test(input string name, input bit ok);
    tests_run++;
    if (ok) begin
      $display("test %-22s ok", name);
    end else begin
      tests_failed++;
      $display("test %-22s had errors", name);
    end
  endtask

  task automatic wait_retire(output bit seen);
    int cycles;
    cycles = 0;
    seen   = 1'b0;
    while (!seen && cycles < retire_wait) begin
      @(negedge clkrst_core_clk);
      cycles++;
      seen = retire_valid;
    end
  endtask

  task automatic check_row(input int r);
    compare(32'(retire_we), 32'(exp_we[r]), $sformatf("row %0d we", r));
    for (int l = 0; l < num_lanes; l++) begin
      if (exp_we[r][l]) begin
        compare(32'(retire_rd_num[l*reg_num_w +: reg_num_w]),
                32'(exp_rd[r][l*reg_num_w +: reg_num_w]),
                $sformatf("row %0d lane %0d rd", r, l));
        compare(retire_rd_data[l*xlen +: xlen], exp_data[r][l*xlen +: xlen],
                $sformatf("row %0d lane %0d data", r, l));
      end
    end
  endtask

  // Cache model decides from values seen at the falling edge
  initial begin
    logic [31:0]        rand_state;
    logic [paddr_w-1:0] paddr_seen;
    bit                 xfer_seen;
    bit                 rst_seen;
    int                 delay;
    int                 next_paddr;
    ic2f_ready  = 1'b0;
    ic2f_packet = '0;
    rand_state  = 32'd29;
    delay       = 0;
    next_paddr  = 0;
    forever begin
      @(negedge clkrst_core_clk);
      rst_seen   = reset;
      xfer_seen  = f2ic_valid && ic2f_ready;
      paddr_seen = f2ic_paddr;
      @(posedge clkrst_core_clk);
      #5;
      if (xfer_seen) begin
        compare(32'(paddr_seen), 32'(next_paddr), "request address");
        next_paddr++;
        rand_state = xorshift32(rand_state);
        delay      = int'(rand_state[1:0]);   // 0 to 3 idle cycles
      end else if (delay != 0) begin
        delay--;
      end
      ic2f_ready  = !rst_seen && delay == 0;
      ic2f_packet = packet_at(f2ic_paddr);
    end
  end

  initial begin
    int errs_before;
    int rows_retired;
    int extra;
    bit seen;
    bit timed_out;
    reset        = 1'b1;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    rows_retired = 0;
    extra        = 0;
    timed_out    = 1'b0;

    add_row(0, "load immediate",
            movi_inst(1, 18'h5), movi_inst(2, 18'h3),
            movi_inst(3, 18'h3fffe), movi_inst(4, 18'h1ffff),
            4'b1111, 1, 2, 3, 4,
            32'h5, 32'h3, 32'hffff_fffe, 32'h0001_ffff);
    add_row(1, "add sub and or",
            alu_inst(op_add, 5, 1, 2), alu_inst(op_sub, 6, 1, 2),
            alu_inst(op_and, 7, 3, 4), alu_inst(op_or, 8, 1, 2),
            4'b1111, 5, 6, 7, 8,
            32'h8, 32'h2, 32'h0001_fffe, 32'h7);
    add_row(2, "xor after dependency",
            alu_inst(op_xor, 9, 5, 6), alu_inst(op_sub, 10, 2, 1),
            alu_inst(op_add, 11, 7, 8), alu_inst(op_xor, 12, 3, 4),
            4'b1111, 9, 10, 11, 12,
            32'ha, 32'hffff_fffe, 32'h0002_0005, 32'hfffe_0001);
    add_row(3, "nop invalid rd0",
            32'h0, alu_inst(4'hf, 13, 1, 2),
            alu_inst(op_add, 0, 1, 2), movi_inst(14, 18'h7),
            4'b1000, 0, 0, 0, 14,
            32'h0, 32'h0, 32'h0, 32'h7);
    add_row(4, "r0 reads zero",
            alu_inst(op_add, 15, 0, 14), alu_inst(op_or, 16, 13, 0),
            alu_inst(op_sub, 17, 0, 1), alu_inst(op_add, 18, 14, 14),
            4'b1111, 15, 16, 17, 18,
            32'h7, 32'h0, 32'hffff_fffb, 32'he);
    add_row(5, "same packet reads",
            movi_inst(1, 18'h64), alu_inst(op_add, 19, 1, 0),
            movi_inst(5, 18'h111), movi_inst(5, 18'h222),
            4'b1111, 1, 19, 5, 5,
            32'h64, 32'h5, 32'h111, 32'h222);
    add_row(6, "higher lane wins",
            alu_inst(op_add, 20, 5, 0), alu_inst(op_add, 21, 1, 19),
            alu_inst(op_xor, 22, 5, 1), alu_inst(op_and, 23, 17, 18),
            4'b1111, 20, 21, 22, 23,
            32'h222, 32'h69, 32'h246, 32'ha);
    add_row(7, "chained results",
            alu_inst(op_sub, 24, 20, 21), alu_inst(op_or, 25, 22, 23),
            movi_inst(26, 18'h3ffff), alu_inst(op_add, 27, 26, 20),
            4'b1111, 24, 25, 26, 27,
            32'h1b9, 32'h24e, 32'hffff_ffff, 32'h222);
    add_row(8, "negative immediates",
            alu_inst(op_add, 28, 26, 26), alu_inst(op_xor, 29, 26, 24),
            movi_inst(30, 18'h20000), alu_inst(op_sub, 31, 0, 26),
            4'b1111, 28, 29, 30, 31,
            32'hffff_fffe, 32'hffff_fe46, 32'hfffe_0000, 32'h1);

    repeat (5) @(posedge clkrst_core_clk);
    #5 reset = 1'b0;

    errs_before = errors;
    @(negedge clkrst_core_clk);
    compare(32'(retire_valid), 32'd0, "retire_valid after reset");
    compare(32'(retire_we), 32'd0, "retire_we after reset");
    compare(32'(f2ic_valid), 32'd1, "f2ic_valid after reset");
    compare(32'(f2ic_paddr), 32'd0, "f2ic_paddr after reset");
    report_test("reset state", errs_before == errors);

    for (int r = 0; r < num_rows && !timed_out; r++) begin
      errs_before = errors;
      wait_retire(seen);
      if (!seen) begin
        $display("timeout: row %0d did not retire within %0d cycles", r, retire_wait);
        timed_out = 1'b1;
      end else begin
        check_row(r);
        rows_retired++;
      end
      report_test(row_name[r], seen && errs_before == errors);
    end

    // Only nop packets may follow the table
    errs_before = errors;
    if (!timed_out) begin
      repeat (40) begin
        @(negedge clkrst_core_clk);
        if (retire_valid && retire_we != '0) begin
          extra++;
        end
      end
    end
    compare(32'(rows_retired + extra), 32'(num_rows), "retired rows");
    report_test("retire count", errs_before == errors && !timed_out);

    $display("%0d tests run, %0d passed, %0d with errors, %0d mismatches",
             tests_run, tests_run - tests_failed, tests_failed, errors);
    if (errors == 0 && !timed_out) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
hw/mcpu_pkg.sv
hw/mcpu_wb_if.sv
hw/mcpu_pipe_reg.sv
hw/mcpu_fetch.sv
hw/mcpu_decode.sv
hw/mcpu_scoreboard.sv
hw/mcpu_regfile.sv
hw/mcpu_execute.sv
hw/mcpu_core.sv
dv/mcpu_core_tb.sv

/* run.sh */
#!/bin/sh
verilator --binary --timing -Wno-fatal -f vlog.f --top-module mcpu_core_tb \
  --Mdir obj_dir -o mcpu_core_sim > build.log 2>&1 \
  && ./obj_dir/mcpu_core_sim > sim.log 2>&1 \
  || { echo "build or simulation error, see build.log and sim.log"; exit 1; }
cat sim.log
grep -q "tests failed" sim.log && exit 1 || exit 0
